//--- Makefile
# Verilator build and run for the fetch subsystem

SIM        := verilator
TOP        := tb_ncpu32k_fetch
FILELIST   := ncpu32k_fetch.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides pass or fail
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/tb_ncpu32k_fetch.sv
// Fetch subsystem testbench
`timescale 1ns/10ps

module tb_ncpu32k_fetch;

   logic                          clk;
   logic                          rst;
   logic                          ibus_valid;
   logic                          ibus_ready;
   logic [ncpu32k_pkg::aw-1:0]    ibus_addr;
   logic [ncpu32k_pkg::iw-1:0]    ibus_insn;
   logic [ncpu32k_pkg::aw-1:0]    ibus_id;
   logic                          idu_ready;
   logic                          idu_valid;
   logic [ncpu32k_pkg::iw-1:0]    idu_insn;
   logic [ncpu32k_pkg::pcw-1:0]   idu_insn_pc;
   logic                          idu_op_jmprel;
   logic                          idu_op_jmpfar;
   logic                          idu_jmprel_link;
   logic                          idu_specul_jmprel;
   logic                          idu_specul_jmpfar;
   logic [ncpu32k_pkg::pcw-1:0]   idu_specul_tgt;
   logic                          idu_specul_bcc;
   logic                          flush;
   logic [ncpu32k_pkg::pcw-1:0]   flush_tgt;
   logic                          bpu_upd;
   logic [ncpu32k_pkg::pcw-1:0]   bpu_upd_pc;
   logic                          bpu_upd_taken;
   logic                          bpu_upd_far;
   logic [ncpu32k_pkg::pcw-1:0]   bpu_upd_tgt;

   // Program memory, 64 words, wraps on the byte address
   logic [31:0]                   mem [64];
   // Reference copy of the predictor state
   logic [1:0]                    cnt_m [16];
   logic [ncpu32k_pkg::pcw-1:0]   tgt_m [16];
   integer                        seed = 32'h5510ea04;
   int                            n_checks;
   int                            n_errors;

   // Expected response for the latest transfer
   logic [31:0]                   exp_addr;
   logic [31:0]                   exp_insn;
   logic [ncpu32k_pkg::pcw-1:0]   exp_pc;
   logic [ncpu32k_pkg::pcw-1:0]   exp_stgt;
   logic                          exp_jmprel;
   logic                          exp_jmpfar;
   logic                          exp_link;
   logic                          exp_sjmprel;
   logic                          exp_sjmpfar;
   logic                          exp_sbcc;

   ncpu32k_fetch ncpu32k_fetch_inst (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Memory model, next word follows ibus_addr of the last transfer
   initial begin
      ibus_valid = 1'b0;
      ibus_insn = '0;
      ibus_id = '0;
      forever begin
         @(posedge clk);
         if (rst) begin
            ibus_valid <= 1'b0;
            ibus_id <= '0;
            ibus_insn <= mem[0];
         end else if (ibus_valid && ibus_ready) begin
            ibus_id <= ibus_addr;
            ibus_insn <= mem[ibus_addr[7:2]];
            ibus_valid <= ($random(seed) & 3) != 0;
         end else if (!ibus_valid) begin
            // Random gaps on the bus
            ibus_valid <= ($random(seed) & 3) != 0;
         end
      end
   end

   function automatic logic [31:0] make_insn(input logic [5:0] op, input logic [25:0] off);
      return {off, op};
   endfunction

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      n_checks++;
      assert (got === exp) else begin
         n_errors++;
         $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   // Expected next address and idu fields from the fetch rules
   task automatic predict(input logic [31:0] id, input logic [31:0] insn, input logic fl,
                          input logic [ncpu32k_pkg::pcw-1:0] ftgt);
      logic [ncpu32k_pkg::pcw-1:0]  pc;
      logic [ncpu32k_pkg::pcw-1:0]  off;
      logic [5:0]                   opc;
      logic [3:0]                   idx;
      logic                         bcc;
      logic                         guess;
      logic                         rel;
      pc = id[31:2];
      opc = insn[5:0];
      off = {{4{insn[31]}}, insn[31:6]};
      idx = pc[3:0];
      bcc = (opc == ncpu32k_pkg::op_bt) || (opc == ncpu32k_pkg::op_bf);
      guess = bcc && cnt_m[idx][1];
      rel = (opc == ncpu32k_pkg::op_jmprel) || (opc == ncpu32k_pkg::op_jmprel_lnk) || guess;
      if (fl) begin
         exp_addr = {ftgt, 2'b00};
      end else if (opc == ncpu32k_pkg::op_jmpfar) begin
         exp_addr = {tgt_m[idx], 2'b00};
      end else if (rel) begin
         exp_addr = {pc + off, 2'b00};
      end else begin
         exp_addr = {pc + 30'd1, 2'b00};
      end
      // Bubble keeps PC and target only
      exp_insn = fl ? '0 : insn;
      exp_pc = pc;
      exp_stgt = guess ? pc + 30'd1 : pc + off;
      exp_jmprel = !fl && (rel || bcc);
      exp_jmpfar = !fl && (opc == ncpu32k_pkg::op_jmpfar);
      exp_link = !fl && (opc == ncpu32k_pkg::op_jmprel_lnk);
      exp_sjmprel = !fl && guess;
      exp_sjmpfar = exp_jmpfar;
      exp_sbcc = !fl && ((guess && opc == ncpu32k_pkg::op_bt) ||
                         (!guess && opc == ncpu32k_pkg::op_bf));
   endtask

   task automatic check_outputs();
      check_val("idu_valid", 32'(idu_valid), 32'd1);
      check_val("idu_insn", idu_insn, exp_insn);
      check_val("idu_insn_pc", 32'(idu_insn_pc), 32'(exp_pc));
      check_val("idu_op_jmprel", 32'(idu_op_jmprel), 32'(exp_jmprel));
      check_val("idu_op_jmpfar", 32'(idu_op_jmpfar), 32'(exp_jmpfar));
      check_val("idu_jmprel_link", 32'(idu_jmprel_link), 32'(exp_link));
      check_val("idu_specul_jmprel", 32'(idu_specul_jmprel), 32'(exp_sjmprel));
      check_val("idu_specul_jmpfar", 32'(idu_specul_jmpfar), 32'(exp_sjmpfar));
      check_val("idu_specul_tgt", 32'(idu_specul_tgt), 32'(exp_stgt));
      check_val("idu_specul_bcc", 32'(idu_specul_bcc), 32'(exp_sbcc));
   endtask

   // One bus transfer, entered and left mid-cycle
   task automatic xfer(input logic chk_id, input logic [31:0] exp_id, input logic rdy_nxt,
                       input logic fl_nxt, input logic [ncpu32k_pkg::pcw-1:0] ftgt_nxt);
      int cycles;
      cycles = 0;
      while (!(ibus_valid && ibus_ready) && cycles < 64) begin
         @(negedge clk);
         cycles++;
      end
      if (!(ibus_valid && ibus_ready)) begin
         n_errors++;
         $display("Timeout at %0t: no instruction bus transfer within 64 cycles", $time);
      end else begin
         if (chk_id) begin
            check_val("ibus_id", ibus_id, exp_id);
         end
         predict(ibus_id, ibus_insn, flush, flush_tgt);
         check_val("ibus_addr", ibus_addr, exp_addr);
         @(posedge clk);
         idu_ready <= rdy_nxt;
         flush <= fl_nxt;
         flush_tgt <= ftgt_nxt;
         @(negedge clk);
         // Captured word one cycle later
         check_outputs();
      end
   endtask

   task automatic fetch_at(input logic [31:0] exp_id);
      xfer(1'b1, exp_id, 1'b1, 1'b0, '0);
   endtask

   // Flush the next transfer over to tgt
   task automatic redirect(input logic [ncpu32k_pkg::pcw-1:0] tgt);
      @(posedge clk);
      flush <= 1'b1;
      flush_tgt <= tgt;
      @(negedge clk);
      xfer(1'b0, '0, 1'b1, 1'b0, '0);
   endtask

   task automatic train(input logic [ncpu32k_pkg::pcw-1:0] pc, input logic taken,
                        input logic far, input logic [ncpu32k_pkg::pcw-1:0] tgt);
      @(posedge clk);
      bpu_upd <= 1'b1;
      bpu_upd_pc <= pc;
      bpu_upd_taken <= taken;
      bpu_upd_far <= far;
      bpu_upd_tgt <= tgt;
      @(posedge clk);
      bpu_upd <= 1'b0;
      // Saturating 2-bit counter or far target
      if (far) begin
         tgt_m[pc[3:0]] = tgt;
      end else if (taken && cnt_m[pc[3:0]] != 2'b11) begin
         cnt_m[pc[3:0]] = cnt_m[pc[3:0]] + 2'd1;
      end else if (!taken && cnt_m[pc[3:0]] != 2'b00) begin
         cnt_m[pc[3:0]] = cnt_m[pc[3:0]] - 2'd1;
      end
      @(negedge clk);
   endtask

   task automatic test_reset();
      @(negedge clk);
      check_val("idu_valid", 32'(idu_valid), 32'd0);
      check_val("ibus_ready", 32'(ibus_ready), 32'd0);
      @(negedge clk);
      check_val("ibus_ready", 32'(ibus_ready), 32'd0);
      @(negedge clk);
      check_val("ibus_ready", 32'(ibus_ready), 32'd1);
      fetch_at(32'd0);
   endtask

   task automatic test_sequential();
      fetch_at(32'd4);
      fetch_at(32'd8);
      fetch_at(32'd12);
   endtask

   task automatic test_jmprel();
      redirect(30'd24);
      fetch_at(32'd96);
      check_val("idu_op_jmprel", 32'(idu_op_jmprel), 32'd1);
      fetch_at(32'd128);
      check_val("idu_jmprel_link", 32'(idu_jmprel_link), 32'd1);
      fetch_at(32'd144);
      // Backward jump below address 0
      redirect(30'd34);
      fetch_at(32'd136);
      fetch_at(32'hffffffe8);
      fetch_at(32'hffffffec);
   endtask

   task automatic test_branch();
      redirect(30'd41);
      fetch_at(32'd164);
      check_val("idu_specul_tgt", 32'(idu_specul_tgt), 32'd47);
      check_val("idu_specul_bcc", 32'(idu_specul_bcc), 32'd0);
      fetch_at(32'd168);
      train(30'd41, 1'b1, 1'b0, '0);
      train(30'd41, 1'b1, 1'b0, '0);
      redirect(30'd41);
      fetch_at(32'd164);
      check_val("idu_specul_tgt", 32'(idu_specul_tgt), 32'd42);
      check_val("idu_specul_bcc", 32'(idu_specul_bcc), 32'd1);
      fetch_at(32'd188);
   endtask

   task automatic test_far();
      train(30'd50, 1'b0, 1'b1, 30'd12);
      redirect(30'd50);
      fetch_at(32'd200);
      check_val("idu_op_jmpfar", 32'(idu_op_jmpfar), 32'd1);
      check_val("idu_specul_jmpfar", 32'(idu_specul_jmpfar), 32'd1);
      fetch_at(32'd48);
   endtask

   task automatic test_backpressure();
      redirect(30'd4);
      xfer(1'b1, 32'd16, 1'b0, 1'b0, '0);
      // Decoder stalled, entry must hold
      repeat (5) begin
         check_val("ibus_ready", 32'(ibus_ready), 32'd0);
         check_outputs();
         @(negedge clk);
      end
      @(posedge clk);
      idu_ready <= 1'b1;
      @(negedge clk);
      fetch_at(32'd20);
   endtask

   task automatic test_flush();
      redirect(30'd23);
      // Flush lands on the jump at word 24
      xfer(1'b1, 32'd92, 1'b1, 1'b1, 30'd40);
      fetch_at(32'd96);
      check_val("idu_insn", idu_insn, 32'd0);
      check_val("idu_op_jmprel", 32'(idu_op_jmprel), 32'd0);
      fetch_at(32'd160);
   endtask

   initial begin
      rst <= 1'b1;
      idu_ready <= 1'b1;
      flush <= 1'b0;
      flush_tgt <= '0;
      bpu_upd <= 1'b0;
      bpu_upd_pc <= '0;
      bpu_upd_taken <= 1'b0;
      bpu_upd_far <= 1'b0;
      bpu_upd_tgt <= '0;
      n_checks = 0;
      n_errors = 0;
      // Plain filler, unique per word
      for (int i = 0; i < 64; i++) begin
         mem[i] = ((32'(i) * 32'h9e3779b1) & 32'hffffffc0) | 32'h20;
      end
      for (int i = 0; i < 16; i++) begin
         cnt_m[i] = 2'b01;
         tgt_m[i] = '0;
      end
      mem[24] = make_insn(ncpu32k_pkg::op_jmprel, 26'd8);
      mem[32] = make_insn(ncpu32k_pkg::op_jmprel_lnk, 26'd4);
      mem[34] = make_insn(ncpu32k_pkg::op_jmprel, 26'h3ffffd8);
      mem[41] = make_insn(ncpu32k_pkg::op_bt, 26'd6);
      mem[50] = make_insn(ncpu32k_pkg::op_jmpfar, 26'd0);
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      test_reset();
      test_sequential();
      test_jmprel();
      test_branch();
      test_far();
      test_backpressure();
      test_flush();
      $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

//--- ncpu32k_fetch.f
verilog/ncpu32k_pkg.sv
verilog/ncpu32k_bpu_if.sv
verilog/ncpu32k_pipebuf.sv
verilog/ncpu32k_ipdu.sv
verilog/ncpu32k_bpu.sv
verilog/ncpu32k_ifu.sv
verilog/ncpu32k_fetch.sv
bench/tb_ncpu32k_fetch.sv

//--- verilog/ncpu32k_bpu.sv
// Branch predictor with far-target table
`timescale 1ns/10ps

module ncpu32k_bpu (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          upd,
   input  logic [ncpu32k_pkg::pcw-1:0]   upd_pc,
   input  logic                          upd_taken,
   input  logic                          upd_far,
   input  logic [ncpu32k_pkg::pcw-1:0]   upd_tgt,
   ncpu32k_bpu_if.bpu                    bif
);

   // 2-bit saturating counters
   logic [1:0]                   cnt [ncpu32k_pkg::bpu_ent];
   // Far jump targets
   logic [ncpu32k_pkg::pcw-1:0]  tgt [ncpu32k_pkg::bpu_ent];

   logic [ncpu32k_pkg::bpu_idx_w-1:0]  rd_idx;
   logic [ncpu32k_pkg::bpu_idx_w-1:0]  upd_idx;

   // Direct-mapped on the low word-PC bits
   assign rd_idx = bif.insn_pc[ncpu32k_pkg::bpu_idx_w-1:0];
   assign upd_idx = upd_pc[ncpu32k_pkg::bpu_idx_w-1:0];

   // Counter MSB is the guess, only for a conditional lookup
   assign bif.taken = bif.rd & bif.jmprel & cnt[rd_idx][1];
   // Far target only for a far lookup
   assign bif.jmp_tgt = (bif.rd & ~bif.jmprel) ? tgt[rd_idx] : '0;

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < ncpu32k_pkg::bpu_ent; i++) begin
            // Weakly not-taken
            cnt[i] <= 2'b01;
            tgt[i] <= '0;
         end
      end else if (upd) begin
         if (upd_far) begin
            tgt[upd_idx] <= upd_tgt;
         end else if (upd_taken) begin
            // Saturate at strongly taken
            if (cnt[upd_idx] != 2'b11) begin
               cnt[upd_idx] <= cnt[upd_idx] + 2'd1;
            end
         end else begin
            // Saturate at strongly not-taken
            if (cnt[upd_idx] != 2'b00) begin
               cnt[upd_idx] <= cnt[upd_idx] - 2'd1;
            end
         end
      end
   end

   // Back end must give a real PC with each update
   property p_upd_pc_known;
      @(posedge clk) disable iff (rst)
         upd |-> !$isunknown(upd_pc);
   endproperty
   a_upd_pc_known: assert property (p_upd_pc_known);

endmodule

//--- verilog/ncpu32k_bpu_if.sv
// Fetch to predictor link
`timescale 1ns/10ps

interface ncpu32k_bpu_if;

   // Lookup request for a conditional or far jump
   logic                          rd;
   // Conditional branch table selected
   logic                          jmprel;
   // Word PC of the word on the bus
   logic [ncpu32k_pkg::pcw-1:0]   insn_pc;
   // Combinational lookup results
   logic                          taken;
   logic [ncpu32k_pkg::pcw-1:0]   jmp_tgt;

   modport ifu (
      output rd, jmprel, insn_pc,
      input  taken, jmp_tgt
   );

   modport bpu (
      input  rd, jmprel, insn_pc,
      output taken, jmp_tgt
   );

endinterface

//--- verilog/ncpu32k_fetch.sv
// Fetch subsystem top level
`timescale 1ns/10ps

module ncpu32k_fetch (
   input  logic                          clk,
   input  logic                          rst,
   // Instruction bus
   input  logic                          ibus_valid,
   output logic                          ibus_ready,
   output logic [ncpu32k_pkg::aw-1:0]    ibus_addr,
   input  logic [ncpu32k_pkg::iw-1:0]    ibus_insn,
   input  logic [ncpu32k_pkg::aw-1:0]    ibus_id,
   // Decoder side
   input  logic                          idu_ready,
   output logic                          idu_valid,
   output logic [ncpu32k_pkg::iw-1:0]    idu_insn,
   output logic [ncpu32k_pkg::pcw-1:0]   idu_insn_pc,
   output logic                          idu_op_jmprel,
   output logic                          idu_op_jmpfar,
   output logic                          idu_jmprel_link,
   output logic                          idu_specul_jmprel,
   output logic                          idu_specul_jmpfar,
   output logic [ncpu32k_pkg::pcw-1:0]   idu_specul_tgt,
   output logic                          idu_specul_bcc,
   // Back-end redirect
   input  logic                          flush,
   input  logic [ncpu32k_pkg::pcw-1:0]   flush_tgt,
   // Predictor training
   input  logic                          bpu_upd,
   input  logic [ncpu32k_pkg::pcw-1:0]   bpu_upd_pc,
   input  logic                          bpu_upd_taken,
   input  logic                          bpu_upd_far,
   input  logic [ncpu32k_pkg::pcw-1:0]   bpu_upd_tgt
);

   ncpu32k_bpu_if bpu_bus ();

   ncpu32k_ifu ifu (
      .clk               (clk),
      .rst               (rst),
      .ibus_valid        (ibus_valid),
      .ibus_ready        (ibus_ready),
      .ibus_addr         (ibus_addr),
      .ibus_insn         (ibus_insn),
      .ibus_id           (ibus_id),
      .flush             (flush),
      .flush_tgt         (flush_tgt),
      .idu_ready         (idu_ready),
      .idu_valid         (idu_valid),
      .idu_insn          (idu_insn),
      .idu_insn_pc       (idu_insn_pc),
      .idu_op_jmprel     (idu_op_jmprel),
      .idu_op_jmpfar     (idu_op_jmpfar),
      .idu_jmprel_link   (idu_jmprel_link),
      .idu_specul_jmprel (idu_specul_jmprel),
      .idu_specul_jmpfar (idu_specul_jmpfar),
      .idu_specul_tgt    (idu_specul_tgt),
      .idu_specul_bcc    (idu_specul_bcc),
      .bif               (bpu_bus.ifu)
   );

   ncpu32k_bpu bpu (
      .clk       (clk),
      .rst       (rst),
      .upd       (bpu_upd),
      .upd_pc    (bpu_upd_pc),
      .upd_taken (bpu_upd_taken),
      .upd_far   (bpu_upd_far),
      .upd_tgt   (bpu_upd_tgt),
      .bif       (bpu_bus.bpu)
   );

endmodule

//--- verilog/ncpu32k_ifu.sv
// Instruction fetch unit
`timescale 1ns/10ps

module ncpu32k_ifu (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          ibus_valid,
   output logic                          ibus_ready,
   output logic [ncpu32k_pkg::aw-1:0]    ibus_addr,
   input  logic [ncpu32k_pkg::iw-1:0]    ibus_insn,
   input  logic [ncpu32k_pkg::aw-1:0]    ibus_id,
   input  logic                          flush,
   input  logic [ncpu32k_pkg::pcw-1:0]   flush_tgt,
   input  logic                          idu_ready,
   output logic                          idu_valid,
   output logic [ncpu32k_pkg::iw-1:0]    idu_insn,
   output logic [ncpu32k_pkg::pcw-1:0]   idu_insn_pc,
   output logic                          idu_op_jmprel,
   output logic                          idu_op_jmpfar,
   output logic                          idu_jmprel_link,
   output logic                          idu_specul_jmprel,
   output logic                          idu_specul_jmpfar,
   output logic [ncpu32k_pkg::pcw-1:0]   idu_specul_tgt,
   output logic                          idu_specul_bcc,
   ncpu32k_bpu_if.ifu                    bif
);

   logic                          jmprel_taken;
   logic                          jmprel_link;
   logic                          op_bcc;
   logic                          op_bt;
   logic                          op_bf;
   logic                          op_jmprel;
   logic                          op_jmpfar;
   logic [ncpu32k_pkg::pcw-1:0]   jmprel_offset;
   logic [1:0]                    rst_cnt;
   logic                          boot_done;
   logic                          fetch_ready;
   logic                          cas;
   logic [ncpu32k_pkg::pcw-1:0]   pc;
   logic [ncpu32k_pkg::pcw-1:0]   pc_seq;
   logic [ncpu32k_pkg::pcw-1:0]   pc_rel;
   logic [ncpu32k_pkg::pcw-1:0]   pc_nxt;
   logic                          sel_far;
   logic                          sel_rel;
   logic                          sel_seq;
   logic                          specul;
   logic                          specul_bcc;
   logic                          keep;

   ncpu32k_ipdu predecoder (
      .insn          (ibus_insn),
      .bpu_taken     (bif.taken),
      .jmprel_taken  (jmprel_taken),
      .jmprel_link   (jmprel_link),
      .op_bcc        (op_bcc),
      .op_bt         (op_bt),
      .op_jmprel     (op_jmprel),
      .op_jmpfar     (op_jmpfar),
      .jmprel_offset (jmprel_offset)
   );

   // Hold the bus off for 2 cycles after reset
   always_ff @(posedge clk) begin
      if (rst) begin
         rst_cnt <= '0;
      end else if (!rst_cnt[1]) begin
         rst_cnt <= rst_cnt + 2'd1;
      end
   end
   assign boot_done = rst_cnt[1];

   ncpu32k_pipebuf pipebuf (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (ibus_valid & boot_done),
      .in_ready  (fetch_ready),
      .out_valid (idu_valid),
      .out_ready (idu_ready),
      .cas       (cas)
   );
   assign ibus_ready = fetch_ready & boot_done;

   // Word PC of the word on the bus
   assign pc = ibus_id[ncpu32k_pkg::aw-1:2];
   assign pc_seq = pc + ncpu32k_pkg::pcw'(1);
   assign pc_rel = pc + jmprel_offset;

   // Predictor lookups
   assign bif.insn_pc = pc;
   assign bif.rd = op_bcc | op_jmpfar;
   assign bif.jmprel = op_bcc;

   // Next PC sources, flush wins
   assign sel_far = op_jmpfar & ~flush;
   assign sel_rel = jmprel_taken & ~flush;
   assign sel_seq = ~op_jmpfar & ~jmprel_taken & ~flush;

   assign pc_nxt = ({ncpu32k_pkg::pcw{sel_far}} & bif.jmp_tgt) |
                   ({ncpu32k_pkg::pcw{sel_rel}} & pc_rel) |
                   ({ncpu32k_pkg::pcw{flush}} & flush_tgt) |
                   ({ncpu32k_pkg::pcw{sel_seq}} & pc_seq);
   assign ibus_addr = {pc_nxt, 2'b00};

   // Speculative paths
   assign specul = (op_bcc & jmprel_taken) | op_jmpfar;
   assign op_bf = op_bcc & ~op_bt;
   // Condition flag the guess assumes
   assign specul_bcc = (bif.taken & op_bt) | (~bif.taken & op_bf);
   // Flushed entries become bubbles
   assign keep = ~flush;

   // Control fields
   always_ff @(posedge clk) begin
      if (rst) begin
         idu_op_jmprel <= 1'b0;
         idu_op_jmpfar <= 1'b0;
         idu_jmprel_link <= 1'b0;
         idu_specul_jmprel <= 1'b0;
         idu_specul_jmpfar <= 1'b0;
         idu_specul_bcc <= 1'b0;
      end else if (cas) begin
         idu_op_jmprel <= op_jmprel & keep;
         idu_op_jmpfar <= op_jmpfar & keep;
         idu_jmprel_link <= jmprel_link & keep;
         idu_specul_jmprel <= specul & op_jmprel & keep;
         idu_specul_jmpfar <= specul & op_jmpfar & keep;
         idu_specul_bcc <= specul_bcc & keep;
      end
   end

   // Payload, PC and the path not followed
   always_ff @(posedge clk) begin
      if (cas) begin
         idu_insn <= ibus_insn & {ncpu32k_pkg::iw{keep}};
         idu_insn_pc <= pc;
         idu_specul_tgt <= bif.taken ? pc_seq : pc_rel;
      end
   end

   // Exactly one next-PC source per presented word
   property p_sel_onehot;
      @(posedge clk) disable iff (rst)
         ibus_valid |-> $onehot({sel_far, sel_rel, flush, sel_seq});
   endproperty
   a_sel_onehot: assert property (p_sel_onehot);

endmodule

//--- verilog/ncpu32k_ipdu.sv
// Instruction predecoder
`timescale 1ns/10ps

module ncpu32k_ipdu (
   input  ncpu32k_pkg::insn_u            insn,
   input  logic                          bpu_taken,
   output logic                          jmprel_taken,
   output logic                          jmprel_link,
   output logic                          op_bcc,
   output logic                          op_bt,
   output logic                          op_jmprel,
   output logic                          op_jmpfar,
   output logic [ncpu32k_pkg::pcw-1:0]   jmprel_offset
);

   logic [ncpu32k_pkg::op_w-1:0]  opc;
   logic                          op_bf;
   logic                          op_jmp;
   logic                          op_lnk;

   // Opcode sits at the same place in both views
   assign opc = insn.far.opcode;

   // Opcode classes
   assign op_jmp = (opc == ncpu32k_pkg::op_jmprel);
   assign op_lnk = (opc == ncpu32k_pkg::op_jmprel_lnk);
   assign op_bt = (opc == ncpu32k_pkg::op_bt);
   assign op_bf = (opc == ncpu32k_pkg::op_bf);
   assign op_jmpfar = (opc == ncpu32k_pkg::op_jmpfar);

   // Conditional branches
   assign op_bcc = op_bt | op_bf;
   // Whole relative class, conditional or not
   assign op_jmprel = op_jmp | op_lnk | op_bcc;
   assign jmprel_link = op_lnk;

   // Unconditional always taken, conditional as predicted
   assign jmprel_taken = op_jmp | op_lnk | (op_bcc & bpu_taken);

   // Signed word offset, widened to the PC
   assign jmprel_offset = {
      {(ncpu32k_pkg::pcw - ncpu32k_pkg::rel_w){insn.rel.offset[ncpu32k_pkg::rel_w-1]}},
      insn.rel.offset
   };

endmodule

//--- verilog/ncpu32k_pipebuf.sv
// One-entry valid/ready buffer
`timescale 1ns/10ps

module ncpu32k_pipebuf (
   input  logic clk,
   input  logic rst,
   input  logic in_valid,
   output logic in_ready,
   output logic out_valid,
   input  logic out_ready,
   output logic cas
);

   logic full;

   // Accept when empty or when the entry drains this cycle
   assign in_ready = out_ready | ~full;
   // Capture strobe for the payload registers
   assign cas = in_valid & in_ready;
   assign out_valid = full;

   always_ff @(posedge clk) begin
      if (rst) begin
         full <= 1'b0;
      end else if (cas) begin
         full <= 1'b1;
      end else if (out_ready) begin
         // Drained with nothing behind it
         full <= 1'b0;
      end
   end

   // Upstream keeps offering a word until it is taken
   property p_hold_valid;
      @(posedge clk) disable iff (rst)
         (in_valid && !in_ready) |=> in_valid;
   endproperty
   a_hold_valid: assert property (p_hold_valid);

endmodule

//--- verilog/ncpu32k_pkg.sv
// Fetch subsystem shared definitions
package ncpu32k_pkg;

   // ISA widths
   localparam int aw = 32;
   localparam int iw = 32;
   // Word PC drops the byte offset
   localparam int pcw = aw - 2;

   // Opcode field and relative offset widths
   localparam int op_w = 6;
   localparam int rel_w = iw - op_w;

   // Opcodes in insn[5:0]
   localparam logic [op_w-1:0] op_jmprel     = 6'h01;
   localparam logic [op_w-1:0] op_jmprel_lnk = 6'h02;
   localparam logic [op_w-1:0] op_bt         = 6'h03;
   localparam logic [op_w-1:0] op_bf         = 6'h04;
   localparam logic [op_w-1:0] op_jmpfar     = 6'h05;

   // One instruction word, two decodings
   typedef union packed {
      // Relative jump or branch, signed word offset
      struct packed {
         logic [rel_w-1:0] offset;
         logic [op_w-1:0]  opcode;
      } rel;
      // Far jump through a register
      struct packed {
         logic [4:0]            rs;
         logic [rel_w-5-1:0]    rsv;
         logic [op_w-1:0]       opcode;
      } far;
   } insn_u;

   // Predictor geometry
   localparam int bpu_ent = 16;
   localparam int bpu_idx_w = 4;

endpackage
